// File: include/memmap_consts.svh
// width and size constants for the memory-map subsystem
// address, core-address and data widths, region count and memory depths

`ifndef MEMMAP_CONSTS_SVH
`define MEMMAP_CONSTS_SVH

// core bus widths
`define MM_AW 32   // full core address
`define MM_AWC 12  // address bits forwarded to a target
`define MM_DW 32   // data width, byte enables are MM_DW/8

// address map
`define MM_NB_REGION 2

// target sizes
`define MM_MEM_WORDS 256  // scratchpad words
`define MM_NB_REGS 8      // implemented peripheral registers

`endif

// File: rtl/core_bus_pkg.sv
// core bus transaction types
// request field types and the response opcode

`include "memmap_consts.svh"

package core_bus_pkg;

  // request fields
  typedef logic [`MM_AW-1:0] addr_t;
  typedef logic [`MM_DW-1:0] data_t;
  typedef logic [`MM_DW/8-1:0] be_t;

  // response status returned with r_valid
  typedef enum logic {
    OPC_OK  = 1'b0,
    OPC_ERR = 1'b1
  } resp_opc_e;

endpackage

// File: rtl/memmap_pkg.sv
// address-map types
// region index and decoder state

`include "memmap_consts.svh"

package memmap_pkg;

  // wide enough to name every region
  typedef logic [$clog2(`MM_NB_REGION)-1:0] region_idx_t;

  // decoder state, ST_RESPONSE for the cycle after a grant
  typedef enum logic {
    ST_IDLE     = 1'b0,
    ST_RESPONSE = 1'b1
  } demux_state_e;

endpackage

// File: rtl/core_bus_if.sv
// core bus port bundle
// request strobe and fields, grant, and the one-cycle response

`timescale 1ns/1ps

interface core_bus_if;

  // request side
  logic                    req;
  logic                    gnt;
  core_bus_pkg::addr_t     add;
  logic                    wen;   // high means read
  core_bus_pkg::be_t       be;
  core_bus_pkg::data_t     data;

  // response side
  logic                    r_valid;
  core_bus_pkg::data_t     r_data;
  core_bus_pkg::resp_opc_e r_opc;

  modport initiator (
    output req,
    output add,
    output wen,
    output be,
    output data,
    input  gnt,
    input  r_valid,
    input  r_data,
    input  r_opc
  );

  modport target (
    input  req,
    input  add,
    input  wen,
    input  be,
    input  data,
    output gnt,
    output r_valid,
    output r_data,
    output r_opc
  );

endinterface

// File: rtl/memmap_demux.sv
// core-side address decoder
// steers each request to one region, translates its address and
// returns that region's response, with a local error answer when unmapped

`timescale 1ns/1ps
`include "memmap_consts.svh"

module memmap_demux (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  input  core_bus_pkg::addr_t [`MM_NB_REGION-1:0] region_start_i,
  input  core_bus_pkg::addr_t [`MM_NB_REGION-1:0] region_end_i,
  core_bus_if.target                             tgt,
  core_bus_if.initiator                          ini [`MM_NB_REGION]
);

  memmap_pkg::demux_state_e state_q, state_d;
  memmap_pkg::region_idx_t  region_d, region_q;

  logic [`MM_NB_REGION-1:0] dest_map;  // one-hot match of the current address
  logic                     hit;
  logic                     granted;
  logic                     err_q;     // pending response is the local error

  logic [`MM_NB_REGION-1:0] ini_gnt;
  logic [`MM_NB_REGION-1:0] ini_r_valid;
  core_bus_pkg::data_t      ini_r_data [`MM_NB_REGION];
  core_bus_pkg::resp_opc_e  ini_r_opc  [`MM_NB_REGION];

  // half-open range compare per region
  always_comb begin
    dest_map = '0;
    region_d = '0;
    for (int unsigned i = 0; i < `MM_NB_REGION; i++) begin
      if ((tgt.add >= region_start_i[i]) && (tgt.add < region_end_i[i])) begin
        dest_map[i] = 1'b1;
        region_d    = memmap_pkg::region_idx_t'(i);
      end
    end
  end

  assign hit = |dest_map;

  // unmapped requests are granted on the spot
  assign tgt.gnt = hit ? ini_gnt[region_d] : tgt.req;
  assign granted = tgt.req & tgt.gnt;

  assign state_d = granted ? memmap_pkg::ST_RESPONSE : memmap_pkg::ST_IDLE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= memmap_pkg::ST_IDLE;
      region_q <= '0;
      err_q    <= 1'b0;
    end else if (clear_i) begin
      state_q  <= memmap_pkg::ST_IDLE;
      region_q <= '0;
      err_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (granted) begin
        region_q <= region_d;  // response source for the next cycle
        err_q    <= ~hit;
      end
    end
  end

  // response path, selected by the region held from the grant
  always_comb begin
    tgt.r_valid = 1'b0;
    tgt.r_data  = '0;
    tgt.r_opc   = core_bus_pkg::OPC_OK;
    if (state_q == memmap_pkg::ST_RESPONSE) begin
      if (err_q) begin
        tgt.r_valid = 1'b1;
        tgt.r_opc   = core_bus_pkg::OPC_ERR;  // data stays zero
      end else begin
        tgt.r_valid = ini_r_valid[region_q];
        tgt.r_data  = ini_r_data[region_q];
        tgt.r_opc   = ini_r_opc[region_q];
      end
    end
  end

  for (genvar g = 0; g < `MM_NB_REGION; g++) begin : gen_region
    assign ini[g].req  = tgt.req & dest_map[g];
    // offset into the region, upper bits forced to zero
    assign ini[g].add  = {{(`MM_AW-`MM_AWC){1'b0}},
                          tgt.add[`MM_AWC-1:0] - region_start_i[g][`MM_AWC-1:0]};
    assign ini[g].wen  = tgt.wen;
    assign ini[g].be   = tgt.be;
    assign ini[g].data = tgt.data;

    assign ini_gnt[g]     = ini[g].gnt;
    assign ini_r_valid[g] = ini[g].r_valid;
    assign ini_r_data[g]  = ini[g].r_data;
    assign ini_r_opc[g]   = ini[g].r_opc;
  end

  // region bounds supplied at run time must not overlap
  a_no_overlap : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tgt.req |-> $onehot0(dest_map)
  ) else $error("address 0x%08h matches more than one region", tgt.add);

  // the granted target answers in the next cycle
  a_rvalid_after_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    granted && !clear_i |=> tgt.r_valid
  ) else $error("no response in the cycle after a grant");

endmodule

// File: rtl/scratch_mem.sv
// region 0 target, byte-enabled scratchpad
// grants at once and answers one cycle after the grant

`timescale 1ns/1ps
`include "memmap_consts.svh"

module scratch_mem (
  input  logic       clk_i,
  input  logic       rst_ni,
  core_bus_if.target bus
);

  localparam int unsigned NB_BE  = `MM_DW / 8;
  localparam int unsigned OFFS_W = $clog2(NB_BE);
  localparam int unsigned IDX_W  = $clog2(`MM_MEM_WORDS);

  core_bus_pkg::data_t mem [`MM_MEM_WORDS];
  core_bus_pkg::data_t r_data_q;
  logic [IDX_W-1:0]    word_idx;
  logic                granted;
  logic                r_valid_q;

  assign word_idx = bus.add[IDX_W+OFFS_W-1:OFFS_W];  // drop the byte offset
  assign bus.gnt  = bus.req;                         // no wait states
  assign granted  = bus.req & bus.gnt;

  // storage and read data
  always_ff @(posedge clk_i) begin
    if (granted) begin
      if (bus.wen) begin
        r_data_q <= mem[word_idx];
      end else begin
        r_data_q <= '0;  // writes answer with zero data
        for (int unsigned b = 0; b < NB_BE; b++) begin
          if (bus.be[b]) begin
            mem[word_idx][8*b +: 8] <= bus.data[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= granted;
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_data  = r_data_q;
  assign bus.r_opc   = core_bus_pkg::OPC_OK;  // every word is implemented

  // the translated offset must stay inside the memory, no aliasing
  a_addr_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus.req |-> (bus.add[`MM_AW-1:IDX_W+OFFS_W] == '0)
  ) else $error("scratchpad address 0x%08h beyond the memory", bus.add);

endmodule

// File: rtl/periph_regs.sv
// region 1 target, small peripheral register bank
// one wait cycle per request, error status beyond the implemented registers

`timescale 1ns/1ps
`include "memmap_consts.svh"

module periph_regs (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  core_bus_if.target bus
);

  localparam int unsigned NB_BE  = `MM_DW / 8;
  localparam int unsigned OFFS_W = $clog2(NB_BE);
  localparam int unsigned IDX_W  = `MM_AWC - OFFS_W;
  localparam int unsigned SEL_W  = $clog2(`MM_NB_REGS);

  core_bus_pkg::data_t     regs [`MM_NB_REGS];
  logic [IDX_W-1:0]        word_idx;
  logic [SEL_W-1:0]        reg_sel;
  logic                    idx_ok;    // word index hits an implemented register
  logic                    wait_q;    // wait cycle already spent
  logic                    granted;
  logic                    r_valid_q;
  core_bus_pkg::data_t     r_data_q;
  core_bus_pkg::resp_opc_e r_opc_q;

  assign word_idx = bus.add[`MM_AWC-1:OFFS_W];
  assign reg_sel  = word_idx[SEL_W-1:0];
  assign idx_ok   = word_idx < IDX_W'(`MM_NB_REGS);

  assign bus.gnt = bus.req & wait_q;  // second cycle of a held request
  assign granted = bus.req & bus.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q    <= 1'b0;
      r_valid_q <= 1'b0;
    end else if (clear_i) begin
      wait_q    <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      wait_q    <= bus.req & ~wait_q;  // drops again after the grant
      r_valid_q <= granted;
    end
  end

  // register bank, writes to missing registers are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < `MM_NB_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (granted && !bus.wen && idx_ok) begin
      for (int unsigned b = 0; b < NB_BE; b++) begin
        if (bus.be[b]) begin
          regs[reg_sel][8*b +: 8] <= bus.data[8*b +: 8];
        end
      end
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (granted) begin
      r_data_q <= (bus.wen && idx_ok) ? regs[reg_sel] : '0;
      r_opc_q  <= idx_ok ? core_bus_pkg::OPC_OK : core_bus_pkg::OPC_ERR;
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_data  = r_data_q;
  assign bus.r_opc   = r_opc_q;

  // a waiting request keeps its fields until it is granted
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus.req && !bus.gnt |=> !bus.req ||
      ($stable(bus.add) && $stable(bus.wen) && $stable(bus.be) && $stable(bus.data))
  ) else $error("request fields changed while waiting for the grant");

endmodule

// File: rtl/memmap_subsys_top.sv
// top level of the memory-map subsystem
// plain core-bus ports, the address decoder and both region targets

`timescale 1ns/1ps
`include "memmap_consts.svh"

module memmap_subsys_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  input  logic                                   req_i,
  input  core_bus_pkg::addr_t                    add_i,
  input  logic                                   wen_i,
  input  core_bus_pkg::be_t                      be_i,
  input  core_bus_pkg::data_t                    data_i,
  input  core_bus_pkg::addr_t [`MM_NB_REGION-1:0] region_start_i,
  input  core_bus_pkg::addr_t [`MM_NB_REGION-1:0] region_end_i,
  output logic                                   gnt_o,
  output logic                                   r_valid_o,
  output core_bus_pkg::data_t                    r_data_o,
  output core_bus_pkg::resp_opc_e                r_opc_o
);

  core_bus_if core_bus ();                      // core port into the decoder
  core_bus_if region_bus [`MM_NB_REGION] ();    // one link per region

  assign core_bus.req  = req_i;
  assign core_bus.add  = add_i;
  assign core_bus.wen  = wen_i;
  assign core_bus.be   = be_i;
  assign core_bus.data = data_i;

  assign gnt_o     = core_bus.gnt;
  assign r_valid_o = core_bus.r_valid;
  assign r_data_o  = core_bus.r_data;
  assign r_opc_o   = core_bus.r_opc;

  memmap_demux u_demux (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .region_start_i (region_start_i),
    .region_end_i   (region_end_i),
    .tgt            (core_bus),
    .ini            (region_bus)
  );

  // region 0
  scratch_mem u_scratch (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (region_bus[0])
  );

  // region 1
  periph_regs u_periph (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .bus     (region_bus[1])
  );

endmodule

// File: tb/tb_memmap.sv
// testbench for the memory-map subsystem
// file-driven core-bus transactions, response checks, timeout and verdict

`timescale 1ns/1ps
`include "memmap_consts.svh"

module tb_memmap;

  logic                                    clk_i = 1'b0;
  logic                                    rst_ni;
  logic                                    clear_i;
  logic                                    req_i;
  core_bus_pkg::addr_t                     add_i;
  logic                                    wen_i;
  core_bus_pkg::be_t                       be_i;
  core_bus_pkg::data_t                     data_i;
  core_bus_pkg::addr_t [`MM_NB_REGION-1:0] region_start;
  core_bus_pkg::addr_t [`MM_NB_REGION-1:0] region_end;
  logic                                    gnt_o;
  logic                                    r_valid_o;
  core_bus_pkg::data_t                     r_data_o;
  core_bus_pkg::resp_opc_e                 r_opc_o;

  // one entry per transaction line of the stimulus file
  logic [7:0]  tx_op    [$];
  logic [31:0] tx_gap   [$];
  logic [31:0] tx_addr  [$];
  logic [31:0] tx_be    [$];
  logic [31:0] tx_wdata [$];
  logic [31:0] tx_rdata [$];
  logic [31:0] tx_opc   [$];
  logic [31:0] tx_lat   [$];

  core_bus_pkg::data_t     exp_data;   // expected answer of the request on the bus
  core_bus_pkg::resp_opc_e exp_opc;
  logic                    pend = 1'b0;  // grant seen in the previous cycle
  core_bus_pkg::data_t     pend_data;
  core_bus_pkg::resp_opc_e pend_opc;
  int unsigned             cycle_cnt = 0;
  int unsigned             cycle_limit = 0;

  memmap_subsys_top uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .req_i          (req_i),
    .add_i          (add_i),
    .wen_i          (wen_i),
    .be_i           (be_i),
    .data_i         (data_i),
    .region_start_i (region_start),
    .region_end_i   (region_end),
    .gnt_o          (gnt_o),
    .r_valid_o      (r_valid_o),
    .r_data_o       (r_data_o),
    .r_opc_o        (r_opc_o)
  );

  always #5 clk_i = ~clk_i;  // 100 MHz

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input core_bus_pkg::data_t got,
                            input core_bus_pkg::data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_opc(input string name, input core_bus_pkg::resp_opc_e got,
                           input core_bus_pkg::resp_opc_e exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_latency(input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      abort_run($sformatf("mismatch gnt_o latency: got 0x%0h expected 0x%0h cycles", got, exp));
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] gap, addr, be, wdata, rdata, opc, lat;
    fd = $fopen("tb/memmap_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open tb/memmap_stimulus.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line[0] == "#") continue;  // comment or empty line
      n = $sscanf(line, "%c %h %h %h %h %h %h %h", op, gap, addr, be, wdata, rdata, opc, lat);
      if (n == 8) begin
        tx_op.push_back(op);
        tx_gap.push_back(gap);
        tx_addr.push_back(addr);
        tx_be.push_back(be);
        tx_wdata.push_back(wdata);
        tx_rdata.push_back(rdata);
        tx_opc.push_back(opc);
        tx_lat.push_back(lat);
      end
    end
    $fclose(fd);
    if (tx_op.size() == 0) begin
      abort_run("the stimulus file holds no transactions");
    end
  endtask

  // response check, one cycle after every grant
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      pend = 1'b0;
    end else begin
      if (pend) begin
        if (!r_valid_o) abort_run("no response in the cycle after a grant");
        check_data("r_data_o", r_data_o, pend_data);
        check_opc("r_opc_o", r_opc_o, pend_opc);
      end else if (r_valid_o) begin
        abort_run("response seen without a grant in the previous cycle");
      end
      pend      = req_i & gnt_o;
      pend_data = exp_data;
      pend_opc  = exp_opc;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout, run still busy after %0d cycles", cycle_limit));
    end
  end

  initial begin
    int unsigned             seed;
    int unsigned             idle;
    int unsigned             lat;
    memmap_pkg::region_idx_t ridx;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    req_i        = 1'b0;
    add_i        = '0;
    wen_i        = 1'b0;
    be_i         = '0;
    data_i       = '0;
    region_start = '0;
    region_end   = '0;
    exp_data     = '0;
    exp_opc      = core_bus_pkg::OPC_OK;
    seed         = $urandom(32'hf964);
    load_stimulus();
    cycle_limit = tx_op.size() * 10 + 3;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    foreach (tx_op[i]) begin
      req_i = 1'b0;
      case (tx_op[i])
        "B": begin  // region bounds, takes no cycle
          ridx               = memmap_pkg::region_idx_t'(tx_be[i]);
          region_start[ridx] = tx_addr[i];
          region_end[ridx]   = tx_wdata[i];
        end
        "C": begin
          clear_i = 1'b1;
          @(negedge clk_i);
          clear_i = 1'b0;
        end
        default: begin
          if (tx_gap[i] != 0) begin
            idle = $urandom % 4;
            repeat (idle) @(negedge clk_i);
          end
          req_i    = 1'b1;
          add_i    = tx_addr[i];
          wen_i    = (tx_op[i] == "R");  // high means read
          be_i     = core_bus_pkg::be_t'(tx_be[i]);
          data_i   = tx_wdata[i];
          exp_data = tx_rdata[i];
          exp_opc  = core_bus_pkg::resp_opc_e'(tx_opc[i][0]);
          lat      = 0;
          do begin
            @(posedge clk_i);
            lat++;
          end while (!gnt_o);
          check_latency(lat, tx_lat[i]);
          @(negedge clk_i);
        end
      endcase
    end

    req_i = 1'b0;
    repeat (2) @(negedge clk_i);  // let the last response be checked
    $display("Everything OK");
    $finish;
  end

endmodule

// File: tb/memmap_stimulus.txt
# columns (hex): op gap addr be wdata exp_rdata exp_opc lat
# op W write, R read, B bounds (be region, addr start, wdata end), C clear; lat = cycles to grant
B 0 10000000 0 10000400 00000000 0 0
B 0 20000100 1 20000200 00000000 0 0
# scratchpad full-word write and read back
W 1 10000000 f deadbeef 00000000 0 1
R 1 10000000 f 00000000 deadbeef 0 1
W 1 100003fc f 0badf00d 00000000 0 1
R 1 100003fc f 00000000 0badf00d 0 1
# partial byte enables merge with earlier data
W 1 10000010 f 11223344 00000000 0 1
W 1 10000010 3 0000aabb 00000000 0 1
W 1 10000010 8 cc000000 00000000 0 1
R 1 10000010 f 00000000 cc22aabb 0 1
W 1 10000014 f 00000000 00000000 0 1
W 1 10000014 6 12345678 00000000 0 1
R 1 10000014 f 00000000 00345600 0 1
# peripheral registers, one wait cycle, offset from region start
W 1 20000100 f a5a5a5a5 00000000 0 2
W 1 2000011c f 13579bdf 00000000 0 2
R 1 20000100 f 00000000 a5a5a5a5 0 2
R 1 2000011c f 00000000 13579bdf 0 2
W 1 20000108 3 0000beef 00000000 0 2
R 1 20000108 f 00000000 0000beef 0 2
R 1 20000104 f 00000000 00000000 0 2
# unimplemented registers and unmapped addresses
W 1 20000120 f ffffffff 00000000 1 2
R 1 20000120 f 00000000 00000000 1 2
R 1 200001fc f 00000000 00000000 1 2
R 1 30000000 f 00000000 00000000 1 1
W 1 00000000 f 12345678 00000000 1 1
R 1 10000400 f 00000000 00000000 1 1
R 1 200000fc f 00000000 00000000 1 1
# back-to-back, alternating regions
W 0 10000020 f 01020304 00000000 0 1
R 0 20000100 f 00000000 a5a5a5a5 0 2
R 0 10000020 f 00000000 01020304 0 1
R 0 2000011c f 00000000 13579bdf 0 2
R 0 10000000 f 00000000 deadbeef 0 1
R 0 30000000 f 00000000 00000000 1 1
R 0 10000010 f 00000000 cc22aabb 0 1
# clear between transactions
R 0 10000000 f 00000000 deadbeef 0 1
C 0 00000000 0 00000000 00000000 0 0
R 1 10000014 f 00000000 00345600 0 1
C 0 00000000 0 00000000 00000000 0 0
C 0 00000000 0 00000000 00000000 0 0
W 1 20000110 f 0f0f0f0f 00000000 0 2
R 0 20000110 f 00000000 0f0f0f0f 0 2

// File: tb.f
+incdir+include
rtl/core_bus_pkg.sv
rtl/memmap_pkg.sv
rtl/core_bus_if.sv
rtl/memmap_demux.sv
rtl/scratch_mem.sv
rtl/periph_regs.sv
rtl/memmap_subsys_top.sv
tb/tb_memmap.sv

// File: Makefile
# Verilator build and run of the memory-map subsystem testbench

TOP = tb_memmap

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: build
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "^Everything OK$$" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
